/* src/spi_flash_pkg.sv */
package spi_flash_pkg;

  typedef logic [23:0] flash_addr_t;  // flash byte address
  typedef logic [31:0] word_t;
  typedef logic [7:0] byte_t;
  typedef logic [2:0] byte_tag_t;  // 0 cmd/addr, 1..4 word byte 0..3
  typedef logic [3:0] cfg_strb_t;

  // driven pin set, io0 and io1 only
  typedef struct packed {
    logic       csb;
    logic       clk;
    logic [1:0] oe;
    logic [1:0] dout;
  } flash_pins_t;

  typedef struct packed {
    byte_t     data;
    byte_tag_t tag;
  } shift_req_t;

  typedef struct packed {
    byte_t     data;
    byte_tag_t tag;
  } shift_rsp_t;

  typedef enum logic [3:0] {
    ST_WAKE_FF,
    ST_WAKE_FF_WAIT,
    ST_WAKE_AB,
    ST_WAKE_AB_WAIT,
    ST_CMD,
    ST_IDLE_CMD,  // command sent, waiting for a request
    ST_ADDR_HI,
    ST_ADDR_MID,
    ST_ADDR_LO,
    ST_DATA_0,
    ST_DATA_1,
    ST_DATA_2,
    ST_DATA_3
  } read_state_t;

  localparam byte_t CMD_WAKE_FF = 8'hff;
  localparam byte_t CMD_RELEASE_PD = 8'hab;
  localparam byte_t CMD_READ = 8'h03;

  localparam int CFG_EN_BIT = 31;
  localparam int CFG_OE_LSB = 8;  // oe at 9:8
  localparam int CFG_CSB_BIT = 5;
  localparam int CFG_CLK_BIT = 4;
  localparam int CFG_DO_LSB = 0;  // dout at 1:0

  localparam int BITS_PER_BYTE = 8;

endpackage

/* src/flash_read_ctrl.sv */
`timescale 1ns/1ps

module flash_read_ctrl (
  input  logic                        clk,
  input  logic                        resetn,
  input  logic                        soft_reset,
  input  logic                        valid,
  input  spi_flash_pkg::flash_addr_t  addr,
  input  logic                        jump,
  input  logic                        prefetch_hold,
  output logic                        req_valid,
  input  logic                        req_ready,
  output spi_flash_pkg::shift_req_t   shift_req,
  input  logic                        rsp_valid,
  output logic                        csb_release
);
  import spi_flash_pkg::*;

  read_state_t state;
  read_state_t after_send;  // state once the byte is accepted
  shift_req_t  next_req;
  logic        send;

  always_comb begin
    send = 1'b0;
    next_req = '{data: 8'h00, tag: 3'd0};
    after_send = state;
    case (state)
      ST_WAKE_FF: begin
        send = 1'b1;
        next_req.data = CMD_WAKE_FF;
        after_send = ST_WAKE_FF_WAIT;
      end
      ST_WAKE_AB: begin
        send = 1'b1;
        next_req.data = CMD_RELEASE_PD;
        after_send = ST_WAKE_AB_WAIT;
      end
      ST_CMD: begin
        send = 1'b1;
        next_req.data = CMD_READ;
        after_send = ST_IDLE_CMD;
      end
      ST_ADDR_HI: begin
        send = 1'b1;
        next_req.data = addr[23:16];
        after_send = ST_ADDR_MID;
      end
      ST_ADDR_MID: begin
        send = 1'b1;
        next_req.data = addr[15:8];
        after_send = ST_ADDR_LO;
      end
      ST_ADDR_LO: begin
        send = 1'b1;
        next_req.data = addr[7:0];
        after_send = ST_DATA_0;
      end
      ST_DATA_0: begin
        send = 1'b1;
        next_req.tag = 3'd1;
        after_send = ST_DATA_1;
      end
      ST_DATA_1: begin
        send = 1'b1;
        next_req.tag = 3'd2;
        after_send = ST_DATA_2;
      end
      ST_DATA_2: begin
        send = 1'b1;
        next_req.tag = 3'd3;
        after_send = ST_DATA_3;
      end
      ST_DATA_3: begin
        send = !prefetch_hold;  // hold last byte of a prefetch
        next_req.tag = 3'd4;
        after_send = ST_DATA_0;
      end
      default: send = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    csb_release <= 1'b0;
    if (!resetn || soft_reset) begin
      state <= ST_WAKE_FF;
      req_valid <= 1'b0;
    end else if (jump) begin
      state <= ST_CMD;  // close the read, new command
      req_valid <= 1'b0;
      csb_release <= 1'b1;
    end else if (req_valid) begin
      if (req_ready) begin
        req_valid <= 1'b0;
        state <= after_send;
      end
    end else if (send) begin
      req_valid <= 1'b1;
      shift_req <= next_req;
    end else begin
      case (state)
        ST_WAKE_FF_WAIT: begin
          if (rsp_valid) begin
            csb_release <= 1'b1;
            state <= ST_WAKE_AB;
          end
        end
        ST_WAKE_AB_WAIT: begin
          if (rsp_valid) begin
            csb_release <= 1'b1;
            state <= ST_CMD;
          end
        end
        ST_IDLE_CMD: begin
          if (valid) state <= ST_ADDR_HI;
        end
        default: state <= state;
      endcase
    end
  end

  // only a jump may withdraw a pending byte
  assert property (@(posedge clk) disable iff (!resetn || soft_reset)
    req_valid && !req_ready && !jump |=> req_valid);

endmodule

/* src/spi_byte_shifter.sv */
`timescale 1ns/1ps

module spi_byte_shifter (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic                       soft_reset,
  input  logic                       csb_release,
  input  logic                       req_valid,
  output logic                       req_ready,
  input  spi_flash_pkg::shift_req_t  shift_req,
  output logic                       rsp_valid,
  output spi_flash_pkg::shift_rsp_t  shift_rsp,
  output spi_flash_pkg::flash_pins_t pins,
  input  logic [1:0]                 flash_din
);
  import spi_flash_pkg::*;

  byte_t     out_shift;
  byte_t     in_shift;
  byte_tag_t xfer_tag;  // travels with the byte
  logic [3:0] bit_count;
  logic      sclk;
  logic      csb;
  logic      rsp_q;

  assign req_ready = (bit_count == 4'd0) && !csb_release;
  assign rsp_valid = rsp_q && !csb_release;  // aborted bytes never surface
  assign shift_rsp = '{data: in_shift, tag: xfer_tag};

  assign pins.csb = csb;
  assign pins.clk = sclk;
  assign pins.oe = 2'b01;  // single bit mode, io0 out
  assign pins.dout = {1'b0, out_shift[7]};

  always_ff @(posedge clk) begin
    if (!resetn || soft_reset) begin
      csb <= 1'b1;
      sclk <= 1'b0;
      bit_count <= 4'd0;
      rsp_q <= 1'b0;
    end else if (csb_release) begin
      csb <= 1'b1;
      sclk <= 1'b0;
      bit_count <= 4'd0;
      rsp_q <= 1'b0;
    end else begin
      rsp_q <= 1'b0;
      if (bit_count != 4'd0) begin
        if (!sclk) begin
          in_shift <= {in_shift[6:0], flash_din[1]};  // sample before rising edge
          sclk <= 1'b1;
        end else begin
          sclk <= 1'b0;
          out_shift <= {out_shift[6:0], 1'b0};
          bit_count <= bit_count - 4'd1;
          if (bit_count == 4'd1) rsp_q <= 1'b1;
        end
      end else if (req_valid) begin
        csb <= 1'b0;
        sclk <= 1'b0;
        bit_count <= 4'(BITS_PER_BYTE);
        out_shift <= shift_req.data;
        xfer_tag <= shift_req.tag;
      end
    end
  end

  assert property (@(posedge clk) disable iff (!resetn || soft_reset || csb_release)
    req_valid && req_ready |=> !csb [* 2 * BITS_PER_BYTE]);

  // response 16 cycles after acceptance
  assert property (@(posedge clk) disable iff (!resetn || soft_reset || csb_release)
    req_valid && req_ready |=> ##(2 * BITS_PER_BYTE) rsp_valid);

endmodule

/* src/flash_cfg_reg.sv */
`timescale 1ns/1ps

module flash_cfg_reg (
  input  logic                       clk,
  input  logic                       resetn,
  input  spi_flash_pkg::cfg_strb_t   cfg_strb,
  input  spi_flash_pkg::word_t       cfg_wdata,
  output spi_flash_pkg::word_t       cfg_rdata,
  input  spi_flash_pkg::flash_pins_t xfer_pins,
  input  logic [1:0]                 flash_din,
  output spi_flash_pkg::flash_pins_t flash,
  output logic                       soft_reset
);
  import spi_flash_pkg::*;

  logic        en;  // 1 = shifter owns the pins
  flash_pins_t bang_pins;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      en <= 1'b1;
      bang_pins <= '{csb: 1'b1, clk: 1'b0, oe: 2'b00, dout: 2'b00};
      soft_reset <= 1'b1;
    end else begin
      soft_reset <= !en || (cfg_strb != '0);  // any write restarts the reader
      if (cfg_strb[CFG_CSB_BIT / BITS_PER_BYTE]) begin
        bang_pins.csb <= cfg_wdata[CFG_CSB_BIT];
        bang_pins.clk <= cfg_wdata[CFG_CLK_BIT];
        bang_pins.dout <= cfg_wdata[CFG_DO_LSB +: 2];
      end
      if (cfg_strb[CFG_OE_LSB / BITS_PER_BYTE]) begin
        bang_pins.oe <= cfg_wdata[CFG_OE_LSB +: 2];
      end
      if (cfg_strb[CFG_EN_BIT / BITS_PER_BYTE]) begin
        en <= cfg_wdata[CFG_EN_BIT];
      end
    end
  end

  assign flash = en ? xfer_pins : bang_pins;

  // readback shows live pins
  always_comb begin
    cfg_rdata = '0;
    cfg_rdata[CFG_EN_BIT] = en;
    cfg_rdata[CFG_OE_LSB +: 2] = flash.oe;
    cfg_rdata[CFG_CSB_BIT] = flash.csb;
    cfg_rdata[CFG_CLK_BIT] = flash.clk;
    cfg_rdata[CFG_DO_LSB +: 2] = flash_din;
  end

endmodule

/* src/read_word_buffer.sv */
`timescale 1ns/1ps

module read_word_buffer (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic                       soft_reset,
  input  logic                       valid,
  input  spi_flash_pkg::flash_addr_t addr,
  input  logic                       rsp_valid,
  input  spi_flash_pkg::shift_rsp_t  shift_rsp,
  output logic                       ready,
  output spi_flash_pkg::word_t       rdata,
  output logic                       jump,
  output logic                       prefetch_hold
);
  import spi_flash_pkg::*;

  byte_t [2:0] low_bytes;  // word bytes 0..2 until the last arrives
  flash_addr_t rd_addr;
  flash_addr_t next_addr;
  logic        rd_valid;
  logic        rd_inc;  // next word is a prefetch
  logic        word_done;

  assign next_addr = rd_addr + 24'd4;
  assign word_done = rsp_valid && (shift_rsp.tag == 3'd4);

  assign ready = valid && rd_valid && (addr == rd_addr);
  assign jump = valid && rd_valid && !ready && (addr != next_addr);

  always_ff @(posedge clk) begin
    if (rsp_valid) begin
      case (shift_rsp.tag)
        3'd1: low_bytes[0] <= shift_rsp.data;
        3'd2: low_bytes[1] <= shift_rsp.data;
        3'd3: low_bytes[2] <= shift_rsp.data;
        3'd4: begin
          rdata <= {shift_rsp.data, low_bytes[2], low_bytes[1], low_bytes[0]};
          rd_addr <= rd_inc ? next_addr : addr;
        end
        default: rdata <= rdata;  // cmd and addr bytes
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn || soft_reset) begin
      rd_valid <= 1'b0;
      rd_inc <= 1'b0;
      prefetch_hold <= 1'b0;
    end else begin
      if (word_done) begin
        rd_valid <= 1'b1;
        rd_inc <= 1'b1;
        prefetch_hold <= rd_inc;  // at most one word ahead
      end
      if (valid) prefetch_hold <= 1'b0;
      if (jump) begin
        rd_valid <= 1'b0;
        rd_inc <= 1'b0;
      end
    end
  end

  // host holds the request until ready
  assert property (@(posedge clk) disable iff (!resetn)
    valid && !ready |=> valid && $stable(addr));

endmodule

/* src/spi_flash_reader.sv */
`timescale 1ns/1ps

module spi_flash_reader (
  input  logic                       clk,
  input  logic                       resetn,
  input  logic                       valid,
  input  spi_flash_pkg::flash_addr_t addr,
  output logic                       ready,
  output spi_flash_pkg::word_t       rdata,
  input  spi_flash_pkg::cfg_strb_t   cfg_strb,
  input  spi_flash_pkg::word_t       cfg_wdata,
  output spi_flash_pkg::word_t       cfg_rdata,
  output spi_flash_pkg::flash_pins_t flash,
  input  logic [1:0]                 flash_din
);
  import spi_flash_pkg::*;

  logic        soft_reset;
  logic        jump;
  logic        prefetch_hold;
  logic        req_valid;
  logic        req_ready;
  logic        csb_release;
  logic        rsp_valid;
  shift_req_t  shift_req;
  shift_rsp_t  shift_rsp;
  flash_pins_t xfer_pins;

  flash_read_ctrl u_ctrl (
    .clk          (clk),
    .resetn       (resetn),
    .soft_reset   (soft_reset),
    .valid        (valid),
    .addr         (addr),
    .jump         (jump),
    .prefetch_hold(prefetch_hold),
    .req_valid    (req_valid),
    .req_ready    (req_ready),
    .shift_req    (shift_req),
    .rsp_valid    (rsp_valid),
    .csb_release  (csb_release)
  );

  spi_byte_shifter u_shifter (
    .clk        (clk),
    .resetn     (resetn),
    .soft_reset (soft_reset),
    .csb_release(csb_release),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .shift_req  (shift_req),
    .rsp_valid  (rsp_valid),
    .shift_rsp  (shift_rsp),
    .pins       (xfer_pins),
    .flash_din  (flash_din)
  );

  flash_cfg_reg u_cfg (
    .clk       (clk),
    .resetn    (resetn),
    .cfg_strb  (cfg_strb),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .xfer_pins (xfer_pins),
    .flash_din (flash_din),
    .flash     (flash),
    .soft_reset(soft_reset)
  );

  read_word_buffer u_buffer (
    .clk          (clk),
    .resetn       (resetn),
    .soft_reset   (soft_reset),
    .valid        (valid),
    .addr         (addr),
    .rsp_valid    (rsp_valid),
    .shift_rsp    (shift_rsp),
    .ready        (ready),
    .rdata        (rdata),
    .jump         (jump),
    .prefetch_hold(prefetch_hold)
  );

endmodule

/* testbench/spi_flash_model.sv */
`timescale 1ns/1ps

module spi_flash_model (
  input  logic                       clk,
  input  spi_flash_pkg::flash_pins_t pins,
  output logic [1:0]                 din
);
  import spi_flash_pkg::*;

  logic [31:0] shift_in = '0;
  byte_t       cmd = 8'h00;
  flash_addr_t read_addr = '0;  // start address of the last 03h read
  logic        prev_clk = 1'b0;
  logic        so_bit = 1'b0;
  int          in_bits = 0;
  int          wake_count = 0;
  int          read_cmd_count = 0;
  int          wakes_at_read = 0;  // wake-ups seen before the last 03h

  assign din = {so_bit, 1'b0};  // io1 carries flash output

  function automatic byte_t rule_byte(input flash_addr_t a);
    return a[7:0] ^ a[15:8] ^ 8'h3c;
  endfunction

  // pins only move on the rising system clock, so look at them mid-cycle
  always @(negedge clk) begin
    logic [31:0] next_shift;
    int          next_bits;
    int          k;
    byte_t       data_byte;
    if (pins.csb !== 1'b0) begin
      in_bits <= 0;
      cmd <= 8'h00;
      so_bit <= 1'b0;
    end else if (pins.clk === 1'b1 && prev_clk === 1'b0) begin
      next_shift = {shift_in[30:0], pins.dout[0]};
      next_bits = in_bits + 1;
      shift_in <= next_shift;
      in_bits <= next_bits;
      if (next_bits == 8) begin
        cmd <= next_shift[7:0];
        if (next_shift[7:0] == CMD_RELEASE_PD) wake_count <= wake_count + 1;
      end
      if (next_bits == 32 && cmd == CMD_READ) begin
        read_addr <= next_shift[23:0];
        read_cmd_count <= read_cmd_count + 1;
        wakes_at_read <= wake_count;
      end
    end else if (pins.clk === 1'b0 && prev_clk === 1'b1 && cmd == CMD_READ && in_bits >= 32) begin
      k = in_bits - 32;  // data bits already clocked out
      data_byte = rule_byte(read_addr + flash_addr_t'(k / 8));
      data_byte = data_byte << (k % 8);
      so_bit <= data_byte[7];  // msb first
    end
    prev_clk <= pins.clk;
  end

endmodule

/* testbench/tb_top.sv */
`timescale 1ns/1ps

module tb_top;
  import spi_flash_pkg::*;

  localparam int MAX_CYCLES = 20000;  // about 40 reads of 150 cycles plus margin
  localparam int GAP_CYCLES = 100;  // room for a full prefetch

  logic        clk = 1'b0;
  logic        resetn;
  logic        valid;
  flash_addr_t addr;
  logic        ready;
  word_t       rdata;
  cfg_strb_t   cfg_strb;
  word_t       cfg_wdata;
  word_t       cfg_rdata;
  flash_pins_t flash_pins;
  logic [1:0]  flash_din;
  int          cycle_count = 0;

  spi_flash_reader DUT (
    .clk      (clk),
    .resetn   (resetn),
    .valid    (valid),
    .addr     (addr),
    .ready    (ready),
    .rdata    (rdata),
    .cfg_strb (cfg_strb),
    .cfg_wdata(cfg_wdata),
    .cfg_rdata(cfg_rdata),
    .flash    (flash_pins),
    .flash_din(flash_din)
  );

  spi_flash_model flash_model (
    .clk (clk),
    .pins(flash_pins),
    .din (flash_din)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("ERRORS FOUND");
      $fatal(1, "run stopped by the cycle limit");
    end
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s: expected %08h, actual %08h", name, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  function automatic byte_t flash_byte(input flash_addr_t a);
    return a[7:0] ^ a[15:8] ^ 8'h3c;
  endfunction

  function automatic word_t expected_word(input flash_addr_t a);
    word_t w;
    for (int i = 0; i < 4; i++) w[8*i +: 8] = flash_byte(a + flash_addr_t'(i));  // little endian
    return w;
  endfunction

  // waits counts the cycles with ready low
  task automatic do_read(input string name, input flash_addr_t a, output int waits);
    waits = 0;
    @(negedge clk);
    valid = 1'b1;
    addr = a;
    #1;  // ready follows the new request
    while (!ready) begin
      waits++;
      @(negedge clk);
    end
    check_value(name, expected_word(a), rdata);
    @(negedge clk);
    valid = 1'b0;
  endtask

  task automatic wakeup_test();
    int waits;
    do_read("wakeup read", 24'h000100, waits);
    check_value("wakeup read commands", 32'd1, flash_model.read_cmd_count);
    check_value("wakeup before read", 32'd1, flash_model.wakes_at_read);
  endtask

  task automatic sequential_test();
    int waits;
    for (int i = 0; i < 8; i++) begin
      do_read($sformatf("seq read %0d", i), 24'h000200 + flash_addr_t'(4 * i), waits);
      if (i >= 2) check_value($sformatf("seq read %0d wait", i), 32'd0, waits);
      repeat (GAP_CYCLES) @(negedge clk);
    end
  endtask

  task automatic jump_test();
    int waits;
    int cmds_before;
    do_read("jump first", 24'h001000, waits);
    cmds_before = flash_model.read_cmd_count;
    do_read("jump second", 24'h00a3c4, waits);
    check_value("jump new command", cmds_before + 1, flash_model.read_cmd_count);
    check_value("jump command addr", 32'h00a3c4, 32'(flash_model.read_addr));
  endtask

  task automatic bitbang_test();
    int          waits;
    int          wakes_before;
    word_t       bang_word;
    word_t       expected_rdata;
    flash_pins_t expected_pins;
    wakes_before = flash_model.wake_count;
    bang_word = '0;
    bang_word[CFG_CLK_BIT] = 1'b1;
    bang_word[CFG_DO_LSB +: 2] = 2'b01;
    expected_pins = '{csb: 1'b0, clk: 1'b1, oe: 2'b00, dout: 2'b01};
    @(negedge clk);
    cfg_strb = 4'b1001;  // en byte and pin byte
    cfg_wdata = bang_word;
    @(negedge clk);
    cfg_strb = '0;
    @(posedge clk);
    check_value("bitbang pins", 32'(expected_pins), 32'(flash_pins));
    expected_rdata = '0;
    expected_rdata[CFG_CLK_BIT] = 1'b1;
    expected_rdata[CFG_DO_LSB +: 2] = flash_din;  // din reads back in place of dout
    check_value("bitbang readback", expected_rdata, cfg_rdata);
    @(negedge clk);
    bang_word = '0;
    bang_word[CFG_EN_BIT] = 1'b1;
    cfg_strb = 4'b1000;
    cfg_wdata = bang_word;
    @(negedge clk);
    cfg_strb = '0;
    do_read("bitbang read", 24'h000040, waits);
    check_value("bitbang wakeup", wakes_before + 1, flash_model.wake_count);
  endtask

  task automatic random_test();
    int          waits;
    logic [31:0] rnd;
    for (int i = 0; i < 20; i++) begin
      rnd = $urandom;
      do_read($sformatf("random read %0d", i), rnd[23:0], waits);
    end
  endtask

  initial begin
    resetn = 1'b0;
    valid = 1'b0;
    addr = '0;
    cfg_strb = '0;
    cfg_wdata = '0;
    void'($urandom(15));
    repeat (10) @(negedge clk);
    resetn = 1'b1;
    wakeup_test();
    sequential_test();
    jump_test();
    bitbang_test();
    random_test();
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* list.f */
src/spi_flash_pkg.sv
src/flash_read_ctrl.sv
src/spi_byte_shifter.sv
src/flash_cfg_reg.sv
src/read_word_buffer.sv
src/spi_flash_reader.sv
testbench/spi_flash_model.sv
testbench/tb_top.sv

/* run_sim.sh */
#!/bin/sh
# build and run the testbench, exit status is the simulation result
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f list.f -o tb_top_sim

./obj_dir/tb_top_sim
